//--- hw/byp_controller.sv
// Module byp_controller: operand and jump-register forwarding selects, load-use and JALR stalls
`timescale 1ns/1ps
`include "byp_defines.svh"

module byp_controller import byp_pkg::*; (
  // From ID
  input  logic [`BYP_NUM_READ_PORTS-1:0] rf_re_i,
  input  rf_addr_t                       rf_raddr_i [`BYP_NUM_READ_PORTS],
  input  logic                           is_jalr_i,
  // EX stage fields
  input  logic                           ex_valid_i,
  input  logic                           ex_rf_we_i,
  input  logic                           ex_lsu_en_i,
  input  rf_addr_t                       ex_waddr_i,
  // WB stage fields
  input  logic                           wb_valid_i,
  input  logic                           wb_rf_we_i,
  input  logic                           wb_lsu_en_i,
  input  rf_addr_t                       wb_waddr_i,
  input  logic                           wb_ready_i,
  // Stalls and selects
  output logic                           load_stall_o,
  output logic                           jr_stall_o,
  output fw_sel_e                        op_a_sel_o,
  output fw_sel_e                        op_b_sel_o,
  output jfw_sel_e                       jalr_sel_o
);

  logic                           rf_we_ex;
  logic                           rf_we_wb;
  logic                           lsu_en_ex;
  logic                           lsu_en_wb;
  logic [`BYP_NUM_READ_PORTS-1:0] rf_rd_ex_match;
  logic [`BYP_NUM_READ_PORTS-1:0] rf_rd_wb_match;

  // EX has priority, it holds the younger result
  function automatic fw_sel_e fw_select(logic ex_hit, logic wb_hit);
    if (ex_hit) begin
      return SEL_FW_EX;
    end else if (wb_hit) begin
      return SEL_FW_WB;
    end
    return SEL_REGFILE;
  endfunction

  // Qualified writers in EX and WB
  assign rf_we_ex  = ex_valid_i && ex_rf_we_i;
  assign rf_we_wb  = wb_valid_i && wb_rf_we_i;
  assign lsu_en_ex = ex_valid_i && ex_lsu_en_i;
  assign lsu_en_wb = wb_valid_i && wb_lsu_en_i;

  //////////////////////////////////////////////////////////////////////
  // Address matching
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `BYP_NUM_READ_PORTS; i++) begin : gen_match
    // Read in ID hits the EX write, x0 never matches
    assign rf_rd_ex_match[i] = rf_we_ex && rf_re_i[i] && (rf_raddr_i[i] != '0) &&
                               (rf_raddr_i[i] == ex_waddr_i);
    // Same against WB
    assign rf_rd_wb_match[i] = rf_we_wb && rf_re_i[i] && (rf_raddr_i[i] != '0) &&
                               (rf_raddr_i[i] == wb_waddr_i);
  end

  //////////////////////////////////////////////////////////////////////
  // Stalls
  //////////////////////////////////////////////////////////////////////

  // Load in EX has no data yet
  // Load in WB without its response cannot forward either
  assign load_stall_o = (lsu_en_ex && |rf_rd_ex_match) ||
                        (!wb_ready_i && |rf_rd_wb_match);

  // JALR always reads rs1 on port 0
  // No EX path to the target, and no load data path from WB
  assign jr_stall_o = is_jalr_i &&
                      (rf_rd_ex_match[0] || (rf_rd_wb_match[0] && lsu_en_wb));

  //////////////////////////////////////////////////////////////////////
  // Forwarding selects
  //////////////////////////////////////////////////////////////////////

  // EX select only taken for ALU results, loads stall above
  assign op_a_sel_o = fw_select(rf_rd_ex_match[0], rf_rd_wb_match[0]);
  assign op_b_sel_o = fw_select(rf_rd_ex_match[1], rf_rd_wb_match[1]);

  // ALU result from WB feeds the target directly
  assign jalr_sel_o = (rf_rd_wb_match[0] && !lsu_en_wb) ? SELJ_FW_WB : SELJ_REGFILE;

endmodule

//--- hw/byp_core_top.sv
// Module byp_core_top: ID, EX and WB stages with bypass controller and register file
`timescale 1ns/1ps
`include "byp_defines.svh"

module byp_core_top import byp_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Instruction input, held while stalled
  input  logic     instr_valid_i,
  input  word_t    instr_i,
  input  word_t    pc_i,
  output logic     stall_o,
  // Read-only data port
  output logic     data_req_o,
  output word_t    data_addr_o,
  input  logic     data_rvalid_i,
  input  word_t    data_rdata_i,
  // Jump and retire reports
  output logic     jump_o,
  output word_t    jump_target_o,
  output logic     retire_valid_o,
  output rf_addr_t retire_waddr_o,
  output word_t    retire_wdata_o
);

  // Register file
  logic [`BYP_NUM_READ_PORTS-1:0] rf_re;
  rf_addr_t                       rf_raddr [`BYP_NUM_READ_PORTS];
  word_t                          rf_rdata [`BYP_NUM_READ_PORTS];
  logic                           rf_we;
  rf_addr_t                       rf_waddr;
  word_t                          rf_wdata;

  // Controller
  logic     is_jalr;
  logic     load_stall;
  logic     jr_stall;
  fw_sel_e  op_a_sel;
  fw_sel_e  op_b_sel;
  jfw_sel_e jalr_sel;

  // EX stage
  logic     ex_valid;
  logic     ex_rf_we;
  logic     ex_lsu_en;
  rf_addr_t ex_waddr;
  alu_op_e  ex_alu_op;
  word_t    ex_op_a;
  word_t    ex_op_b;
  word_t    ex_fw_data;

  // WB stage
  logic     wb_valid;
  logic     wb_rf_we;
  logic     wb_lsu_en;
  rf_addr_t wb_waddr;
  word_t    wb_alu_result;
  logic     wb_ready;
  word_t    wb_fw_data;

  byp_id_stage u_id_stage (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rf_re_o       (rf_re),
    .rf_raddr_o    (rf_raddr),
    .rf_rdata_i    (rf_rdata),
    .is_jalr_o     (is_jalr),
    .rd_waddr_o    (),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .jalr_sel_i    (jalr_sel),
    .ex_fw_data_i  (ex_fw_data),
    .wb_fw_data_i  (wb_fw_data),
    .load_stall_i  (load_stall),
    .jr_stall_i    (jr_stall),
    .wb_ready_i    (wb_ready),
    .stall_o       (stall_o),
    .jump_o        (jump_o),
    .jump_target_o (jump_target_o),
    .ex_valid_o    (ex_valid),
    .ex_rf_we_o    (ex_rf_we),
    .ex_lsu_en_o   (ex_lsu_en),
    .ex_waddr_o    (ex_waddr),
    .ex_alu_op_o   (ex_alu_op),
    .ex_op_a_o     (ex_op_a),
    .ex_op_b_o     (ex_op_b)
  );

  byp_controller u_controller (
    .rf_re_i      (rf_re),
    .rf_raddr_i   (rf_raddr),
    .is_jalr_i    (is_jalr),
    .ex_valid_i   (ex_valid),
    .ex_rf_we_i   (ex_rf_we),
    .ex_lsu_en_i  (ex_lsu_en),
    .ex_waddr_i   (ex_waddr),
    .wb_valid_i   (wb_valid),
    .wb_rf_we_i   (wb_rf_we),
    .wb_lsu_en_i  (wb_lsu_en),
    .wb_waddr_i   (wb_waddr),
    .wb_ready_i   (wb_ready),
    .load_stall_o (load_stall),
    .jr_stall_o   (jr_stall),
    .op_a_sel_o   (op_a_sel),
    .op_b_sel_o   (op_b_sel),
    .jalr_sel_o   (jalr_sel)
  );

  byp_ex_stage u_ex_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .ex_valid_i      (ex_valid),
    .ex_rf_we_i      (ex_rf_we),
    .ex_lsu_en_i     (ex_lsu_en),
    .ex_waddr_i      (ex_waddr),
    .ex_alu_op_i     (ex_alu_op),
    .ex_op_a_i       (ex_op_a),
    .ex_op_b_i       (ex_op_b),
    .wb_ready_i      (wb_ready),
    .ex_fw_data_o    (ex_fw_data),
    .data_req_o      (data_req_o),
    .data_addr_o     (data_addr_o),
    .wb_valid_o      (wb_valid),
    .wb_rf_we_o      (wb_rf_we),
    .wb_lsu_en_o     (wb_lsu_en),
    .wb_waddr_o      (wb_waddr),
    .wb_alu_result_o (wb_alu_result)
  );

  byp_wb_stage u_wb_stage (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .wb_valid_i      (wb_valid),
    .wb_rf_we_i      (wb_rf_we),
    .wb_lsu_en_i     (wb_lsu_en),
    .wb_waddr_i      (wb_waddr),
    .wb_alu_result_i (wb_alu_result),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .wb_ready_o      (wb_ready),
    .wb_fw_data_o    (wb_fw_data),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata),
    .retire_valid_o  (retire_valid_o),
    .retire_waddr_o  (retire_waddr_o),
    .retire_wdata_o  (retire_wdata_o)
  );

  byp_regfile u_regfile (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .raddr_i  (rf_raddr),
    .rdata_o  (rf_rdata),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

endmodule

//--- hw/byp_defines.svh
// Width and count macros for the bypass datapath: data width, register index width, read ports
`ifndef BYP_DEFINES_SVH
`define BYP_DEFINES_SVH

// Data and pc width
`define BYP_XLEN 32

// Register index width, 32 registers
`define BYP_RF_ADDR_W 5

// Read ports on the register file, rs1 and rs2
`define BYP_NUM_READ_PORTS 2

`endif

//--- hw/byp_ex_stage.sv
// Module byp_ex_stage: ALU, load address and data request, EX/WB register
`timescale 1ns/1ps

module byp_ex_stage import byp_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // ID/EX register
  input  logic     ex_valid_i,
  input  logic     ex_rf_we_i,
  input  logic     ex_lsu_en_i,
  input  rf_addr_t ex_waddr_i,
  input  alu_op_e  ex_alu_op_i,
  input  word_t    ex_op_a_i,
  input  word_t    ex_op_b_i,
  // WB can take a new entry
  input  logic     wb_ready_i,
  // Result forwarded to ID
  output word_t    ex_fw_data_o,
  // Data port request
  output logic     data_req_o,
  output word_t    data_addr_o,
  // EX/WB register
  output logic     wb_valid_o,
  output logic     wb_rf_we_o,
  output logic     wb_lsu_en_o,
  output rf_addr_t wb_waddr_o,
  output word_t    wb_alu_result_o
);

  word_t alu_result;

  always_comb begin
    case (ex_alu_op_i)
      ALU_SUB: alu_result = ex_op_a_i - ex_op_b_i;
      ALU_AND: alu_result = ex_op_a_i & ex_op_b_i;
      ALU_OR:  alu_result = ex_op_a_i | ex_op_b_i;
      ALU_XOR: alu_result = ex_op_a_i ^ ex_op_b_i;
      default: alu_result = ex_op_a_i + ex_op_b_i;
    endcase
  end

  assign ex_fw_data_o = alu_result;

  // Loads decode as ADD of rs1 and offset
  assign data_addr_o = alu_result;

  // Only while no older load waits in WB, so one request is outstanding
  // The load moves to WB at the same edge, so it requests once
  assign data_req_o = ex_valid_i && ex_lsu_en_i && wb_ready_i;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o  <= 1'b0;
      wb_rf_we_o  <= 1'b0;
      wb_lsu_en_o <= 1'b0;
    end else if (wb_ready_i) begin
      // Empty EX leaves a bubble in WB
      wb_valid_o  <= ex_valid_i;
      wb_rf_we_o  <= ex_valid_i && ex_rf_we_i;
      wb_lsu_en_o <= ex_valid_i && ex_lsu_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_ready_i && ex_valid_i) begin
      wb_waddr_o      <= ex_waddr_i;
      wb_alu_result_o <= alu_result;
    end
  end

endmodule

//--- hw/byp_id_stage.sv
// Module byp_id_stage: decoder, register read, operand forwarding, JALR target, ID/EX register
`timescale 1ns/1ps
`include "byp_defines.svh"

module byp_id_stage import byp_pkg::*; (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  // Instruction input
  input  logic                           instr_valid_i,
  input  word_t                          instr_i,
  input  word_t                          pc_i,
  // Register file read
  output logic [`BYP_NUM_READ_PORTS-1:0] rf_re_o,
  output rf_addr_t                       rf_raddr_o [`BYP_NUM_READ_PORTS],
  input  word_t                          rf_rdata_i [`BYP_NUM_READ_PORTS],
  // Decode info
  output logic                           is_jalr_o,
  output rf_addr_t                       rd_waddr_o,
  // Forwarding
  input  fw_sel_e                        op_a_sel_i,
  input  fw_sel_e                        op_b_sel_i,
  input  jfw_sel_e                       jalr_sel_i,
  input  word_t                          ex_fw_data_i,
  input  word_t                          wb_fw_data_i,
  // Hazards
  input  logic                           load_stall_i,
  input  logic                           jr_stall_i,
  input  logic                           wb_ready_i,
  output logic                           stall_o,
  // Jump report
  output logic                           jump_o,
  output word_t                          jump_target_o,
  // ID/EX register
  output logic                           ex_valid_o,
  output logic                           ex_rf_we_o,
  output logic                           ex_lsu_en_o,
  output rf_addr_t                       ex_waddr_o,
  output alu_op_e                        ex_alu_op_o,
  output word_t                          ex_op_a_o,
  output word_t                          ex_op_b_o
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm;
  logic       dec_valid;
  logic       use_imm;
  logic       is_lw;
  alu_op_e    alu_op;
  word_t      fw_a;
  word_t      fw_b;
  word_t      op_a;
  word_t      op_b;
  word_t      jr_base;
  logic       hazard;
  logic       take;

  // Pick one operand source
  function automatic word_t fw_mux(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign opcode        = instr_i[6:0];
  assign funct3        = instr_i[14:12];
  assign rd_waddr_o    = instr_i[11:7];
  assign rf_raddr_o[0] = instr_i[19:15];
  assign rf_raddr_o[1] = instr_i[24:20];
  // I-type immediate, sign extended
  assign imm = {{(`BYP_XLEN-12){instr_i[31]}}, instr_i[31:20]};

  always_comb begin
    dec_valid = 1'b0;
    use_imm   = 1'b0;
    is_lw     = 1'b0;
    is_jalr_o = 1'b0;
    alu_op    = ALU_ADD;
    rf_re_o   = '0;
    // Idle input reads nothing, so no false hazards
    if (instr_valid_i) begin
      case (opcode)
        OPC_OP: begin
          rf_re_o   = '1;
          dec_valid = 1'b1;
          case (funct3)
            3'b000:  alu_op = instr_i[30] ? ALU_SUB : ALU_ADD;
            3'b100:  alu_op = ALU_XOR;
            3'b110:  alu_op = ALU_OR;
            3'b111:  alu_op = ALU_AND;
            default: dec_valid = 1'b0;
          endcase
        end
        OPC_OP_IMM: begin
          rf_re_o[0] = 1'b1;
          use_imm    = 1'b1;
          dec_valid  = (funct3 == 3'b000);
        end
        OPC_LOAD: begin
          rf_re_o[0] = 1'b1;
          use_imm    = 1'b1;
          dec_valid  = (funct3 == 3'b010);
          is_lw      = dec_valid;
        end
        OPC_JALR: begin
          // rs1 only feeds the target
          rf_re_o[0] = 1'b1;
          dec_valid  = (funct3 == 3'b000);
          is_jalr_o  = dec_valid;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operands and jump target
  //////////////////////////////////////////////////////////////////////

  assign fw_a = fw_mux(op_a_sel_i, rf_rdata_i[0], ex_fw_data_i, wb_fw_data_i);
  assign fw_b = fw_mux(op_b_sel_i, rf_rdata_i[1], ex_fw_data_i, wb_fw_data_i);

  // JALR writes pc + 4 through the ALU adder
  assign op_a = is_jalr_o ? pc_i : fw_a;
  assign op_b = is_jalr_o ? word_t'(4) : (use_imm ? imm : fw_b);

  // Target uses the WB path only, EX matches stall instead
  assign jr_base       = (jalr_sel_i == SELJ_FW_WB) ? wb_fw_data_i : rf_rdata_i[0];
  assign jump_target_o = (jr_base + imm) & ~word_t'(1);

  assign hazard  = load_stall_i || jr_stall_i;
  assign stall_o = hazard || !wb_ready_i;
  assign jump_o  = is_jalr_o && !stall_o;
  // Instruction leaves ID at this edge
  assign take    = instr_valid_i && !stall_o;

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o  <= 1'b0;
      ex_rf_we_o  <= 1'b0;
      ex_lsu_en_o <= 1'b0;
    end else if (wb_ready_i) begin
      // Bubble on a hazard, hold while WB waits
      ex_valid_o  <= take;
      ex_rf_we_o  <= take && dec_valid;
      ex_lsu_en_o <= take && is_lw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      ex_waddr_o  <= rd_waddr_o;
      ex_alu_op_o <= alu_op;
      ex_op_a_o   <= op_a;
      ex_op_b_o   <= op_b;
    end
  end

endmodule

//--- hw/byp_pkg.sv
// Package byp_pkg: word and register index types, ALU op, forwarding select and LSU state enums
`include "byp_defines.svh"

package byp_pkg;

  // Data or pc word
  typedef logic [`BYP_XLEN-1:0] word_t;

  // Register file index
  typedef logic [`BYP_RF_ADDR_W-1:0] rf_addr_t;

  // ALU operations of the decoded subset
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SUB = 3'b001,
    ALU_AND = 3'b010,
    ALU_OR  = 3'b011,
    ALU_XOR = 3'b100
  } alu_op_e;

  // Operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Jump register source, no EX path
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jfw_sel_e;

  // WB load response tracking
  typedef enum logic {
    LSU_IDLE = 1'b0,
    LSU_WAIT = 1'b1
  } lsu_state_e;

endpackage

//--- hw/byp_regfile.sv
// Module byp_regfile: 32-entry register file, two combinational reads, one write, x0 fixed at zero
`timescale 1ns/1ps
`include "byp_defines.svh"

module byp_regfile import byp_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Read ports, rs1 then rs2
  input  rf_addr_t raddr_i [`BYP_NUM_READ_PORTS],
  output word_t    rdata_o [`BYP_NUM_READ_PORTS],
  // Write port from WB
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  localparam int NUM_REGS = 1 << `BYP_RF_ADDR_W;

  word_t regs_q [NUM_REGS];

  // Write at the edge, so a same-cycle read still sees the old value
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // x0 never written
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  for (genvar i = 0; i < `BYP_NUM_READ_PORTS; i++) begin : gen_read
    assign rdata_o[i] = regs_q[raddr_i[i]];
  end

endmodule

//--- hw/byp_wb_stage.sv
// Module byp_wb_stage: load response wait FSM, writeback select, register write and retire report
`timescale 1ns/1ps

module byp_wb_stage import byp_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // EX/WB register
  input  logic     wb_valid_i,
  input  logic     wb_rf_we_i,
  input  logic     wb_lsu_en_i,
  input  rf_addr_t wb_waddr_i,
  input  word_t    wb_alu_result_i,
  // Data port response
  input  logic     data_rvalid_i,
  input  word_t    data_rdata_i,
  // Pipeline control and forwarding
  output logic     wb_ready_o,
  output word_t    wb_fw_data_o,
  // Register file write
  output logic     rf_we_o,
  output rf_addr_t rf_waddr_o,
  output word_t    rf_wdata_o,
  // Retire report
  output logic     retire_valid_o,
  output rf_addr_t retire_waddr_o,
  output word_t    retire_wdata_o
);

  lsu_state_e lsu_state_q;
  lsu_state_e lsu_state_d;
  logic       load_in_wb;
  logic       load_done;

  assign load_in_wb = wb_valid_i && wb_lsu_en_i;

  // Response belongs to the load in WB, either just arrived or waiting
  assign load_done = data_rvalid_i && (load_in_wb || (lsu_state_q == LSU_WAIT));

  //////////////////////////////////////////////////////////////////////
  // Load wait FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    lsu_state_d = lsu_state_q;
    case (lsu_state_q)
      LSU_IDLE: begin
        // Data may come in the first WB cycle
        if (load_in_wb && !data_rvalid_i) begin
          lsu_state_d = LSU_WAIT;
        end
      end
      LSU_WAIT: begin
        if (data_rvalid_i) begin
          lsu_state_d = LSU_IDLE;
        end
      end
      default: lsu_state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lsu_state_q <= LSU_IDLE;
    end else begin
      lsu_state_q <= lsu_state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////////////////////////

  // Whole pipe holds while a load lacks data
  assign wb_ready_o = !load_in_wb || load_done;

  // Load data only in its arrival cycle
  assign wb_fw_data_o = load_done ? data_rdata_i : wb_alu_result_i;

  assign retire_valid_o = wb_valid_i && (!wb_lsu_en_i || load_done);
  assign retire_waddr_o = wb_waddr_i;
  assign retire_wdata_o = wb_fw_data_o;

  // Writes to x0 are dropped in the register file
  assign rf_we_o    = retire_valid_o && wb_rf_we_i;
  assign rf_waddr_o = wb_waddr_i;
  assign rf_wdata_o = wb_fw_data_o;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir obj_dir

out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi

//--- tb.f
+incdir+hw
hw/byp_pkg.sv
hw/byp_regfile.sv
hw/byp_id_stage.sv
hw/byp_controller.sv
hw/byp_ex_stage.sv
hw/byp_wb_stage.sv
hw/byp_core_top.sv
testbench/tb_top.sv

//--- testbench/tb_top.sv
// Testbench tb_top: clock, reset, random program, data memory model, ISA reference model and checks
`timescale 1ns/1ps

module tb_top import byp_pkg::*; ();

  localparam int NUM_INSTR      = 2000;
  localparam int RESET_CYCLES   = 10;
  localparam int DRAIN_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + RESET_CYCLES + DRAIN_CYCLES;

  // RV32I opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Instruction kinds of the random program
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_ADDI = 5;
  localparam int K_LW   = 6;
  localparam int K_JALR = 7;

  // DUT ports
  logic     clk_i = 1'b0;
  logic     arst_n_i;
  logic     instr_valid_i;
  word_t    instr_i;
  word_t    pc_i;
  logic     stall_o;
  logic     data_req_o;
  word_t    data_addr_o;
  logic     data_rvalid_i;
  word_t    data_rdata_i;
  logic     jump_o;
  word_t    jump_target_o;
  logic     retire_valid_o;
  rf_addr_t retire_waddr_o;
  word_t    retire_wdata_o;

  // Instruction currently presented
  int       cur_kind;
  rf_addr_t cur_rd;
  rf_addr_t cur_rs1;
  rf_addr_t cur_rs2;
  word_t    cur_imm;
  word_t    cur_pc;
  word_t    next_pc;
  logic     hold;
  int       accepted;

  // ISA model state and expectations
  word_t    model_regs [32];
  rf_addr_t exp_waddr_q [$];
  word_t    exp_wdata_q [$];
  word_t    exp_jump_q [$];
  word_t    exp_laddr_q [$];

  // Data memory model
  logic     outstanding;
  logic     resp_pending;
  int       resp_wait;
  word_t    resp_data;

  // Error counters
  int       err_retire;
  int       err_jump;
  int       err_load;
  int       err_misc;
  int       cycle_cnt;

  always #4 clk_i = ~clk_i;

  byp_core_top DUT (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .stall_o        (stall_o),
    .data_req_o     (data_req_o),
    .data_addr_o    (data_addr_o),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .jump_o         (jump_o),
    .jump_target_o  (jump_target_o),
    .retire_valid_o (retire_valid_o),
    .retire_waddr_o (retire_waddr_o),
    .retire_wdata_o (retire_wdata_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory contents and program generation
  //////////////////////////////////////////////////////////////////////

  // Read data as a fixed hash over the whole address
  function automatic word_t mem_hash(word_t addr);
    word_t h;
    h = addr * 32'h9e37_79b1;
    h = h ^ (h >> 15) ^ {addr[15:0], addr[31:16]};
    return h;
  endfunction

  // Random instruction on x0..x7, so hazards are frequent
  task automatic new_instruction();
    logic [11:0] imm12;
    cur_kind = int'($urandom_range(7, 0));
    cur_rd   = 5'($urandom_range(7, 0));
    cur_rs1  = 5'($urandom_range(7, 0));
    cur_rs2  = 5'($urandom_range(7, 0));
    imm12    = 12'($urandom);
    cur_imm  = {{20{imm12[11]}}, imm12};
    cur_pc   = next_pc;
    case (cur_kind)
      K_ADD:   instr_i = {7'b0000000, cur_rs2, cur_rs1, 3'b000, cur_rd, OPC_OP};
      K_SUB:   instr_i = {7'b0100000, cur_rs2, cur_rs1, 3'b000, cur_rd, OPC_OP};
      K_AND:   instr_i = {7'b0000000, cur_rs2, cur_rs1, 3'b111, cur_rd, OPC_OP};
      K_OR:    instr_i = {7'b0000000, cur_rs2, cur_rs1, 3'b110, cur_rd, OPC_OP};
      K_XOR:   instr_i = {7'b0000000, cur_rs2, cur_rs1, 3'b100, cur_rd, OPC_OP};
      K_ADDI:  instr_i = {imm12, cur_rs1, 3'b000, cur_rd, OPC_OP_IMM};
      K_LW:    instr_i = {imm12, cur_rs1, 3'b010, cur_rd, OPC_LOAD};
      default: instr_i = {imm12, cur_rs1, 3'b000, cur_rd, OPC_JALR};
    endcase
    pc_i          = cur_pc;
    instr_valid_i = 1'b1;
  endtask

  // In-order ISA step for one accepted instruction
  task automatic execute_model();
    word_t a;
    word_t b;
    word_t res;
    word_t addr;
    a = model_regs[cur_rs1];
    b = model_regs[cur_rs2];
    case (cur_kind)
      K_ADD:  res = a + b;
      K_SUB:  res = a - b;
      K_AND:  res = a & b;
      K_OR:   res = a | b;
      K_XOR:  res = a ^ b;
      K_ADDI: res = a + cur_imm;
      K_LW: begin
        addr = a + cur_imm;
        exp_laddr_q.push_back(addr);
        res = mem_hash(addr);
      end
      default: begin
        // JALR target with bit zero cleared, link is pc + 4
        exp_jump_q.push_back((a + cur_imm) & ~32'd1);
        res = cur_pc + 32'd4;
      end
    endcase
    exp_waddr_q.push_back(cur_rd);
    exp_wdata_q.push_back(res);
    if (cur_rd != 5'd0) begin
      model_regs[cur_rd] = res;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive and sample
  //////////////////////////////////////////////////////////////////////

  // Called just after the rising edge
  task automatic drive_inputs();
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    if (resp_pending) begin
      if (resp_wait == 0) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = resp_data;
        resp_pending  = 1'b0;
      end else begin
        resp_wait--;
      end
    end
    // A stalled instruction stays on the input
    if (!hold) begin
      if (accepted < NUM_INSTR && $urandom_range(9, 0) >= 2) begin
        new_instruction();
      end else begin
        instr_valid_i = 1'b0;
      end
    end
  endtask

  task automatic check_jump();
    word_t exp_target;
    if (jump_o) begin
      assert (exp_jump_q.size() != 0) else begin
        err_jump++;
        $display("Jump reported with no JALR leaving ID");
      end
      if (exp_jump_q.size() != 0) begin
        exp_target = exp_jump_q.pop_front();
        assert (jump_target_o == exp_target) else begin
          err_jump++;
          $display("Fail jump_target_o: got %h expected %h", jump_target_o, exp_target);
        end
      end
    end
  endtask

  task automatic check_retire();
    rf_addr_t exp_waddr;
    word_t    exp_wdata;
    if (retire_valid_o) begin
      assert (exp_waddr_q.size() != 0) else begin
        err_retire++;
        $display("Retire reported with no instruction left to complete");
      end
      if (exp_waddr_q.size() != 0) begin
        exp_waddr = exp_waddr_q.pop_front();
        exp_wdata = exp_wdata_q.pop_front();
        assert (retire_waddr_o == exp_waddr) else begin
          err_retire++;
          $display("Fail retire_waddr_o: got %h expected %h", retire_waddr_o, exp_waddr);
        end
        assert (retire_wdata_o == exp_wdata) else begin
          err_retire++;
          $display("Fail retire_wdata_o: got %h expected %h", retire_wdata_o, exp_wdata);
        end
      end
    end
  endtask

  task automatic check_load_request();
    word_t exp_addr;
    // Response in this cycle closes the outstanding load
    if (data_rvalid_i) begin
      outstanding = 1'b0;
    end
    if (data_req_o) begin
      assert (!outstanding) else begin
        err_load++;
        $display("Data request issued while a load was still outstanding");
      end
      assert (exp_laddr_q.size() != 0) else begin
        err_load++;
        $display("Data request issued with no load expected");
      end
      if (exp_laddr_q.size() != 0) begin
        exp_addr = exp_laddr_q.pop_front();
        assert (data_addr_o == exp_addr) else begin
          err_load++;
          $display("Fail data_addr_o: got %h expected %h", data_addr_o, exp_addr);
        end
      end
      // Schedule the response, 0 to 4 cycles after the load reaches WB
      outstanding  = 1'b1;
      resp_pending = 1'b1;
      resp_wait    = int'($urandom_range(4, 0));
      resp_data    = mem_hash(data_addr_o);
    end
  endtask

  // Called at the falling edge, where outputs are settled
  task automatic sample_outputs();
    if (instr_valid_i && !stall_o) begin
      execute_model();
      accepted++;
      next_pc = next_pc + 32'd4;
    end
    hold = instr_valid_i && stall_o;
    check_jump();
    check_retire();
    check_load_request();
  endtask

  task automatic check_reset_outputs();
    assert (!stall_o) else begin
      err_misc++;
      $display("Fail stall_o: got %h expected 0", stall_o);
    end
    assert (!retire_valid_o) else begin
      err_misc++;
      $display("Fail retire_valid_o: got %h expected 0", retire_valid_o);
    end
    assert (!jump_o) else begin
      err_misc++;
      $display("Fail jump_o: got %h expected 0", jump_o);
    end
    assert (!data_req_o) else begin
      err_misc++;
      $display("Fail data_req_o: got %h expected 0", data_req_o);
    end
  endtask

  task automatic print_counts();
    $display("Errors: retire %0d, jump %0d, load %0d, other %0d, cycles %0d",
             err_retire, err_jump, err_load, err_misc, cycle_cnt);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hb781));
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    hold          = 1'b0;
    accepted      = 0;
    next_pc       = 32'h0000_1000;
    outstanding   = 1'b0;
    resp_pending  = 1'b0;
    resp_wait     = 0;
    resp_data     = '0;
    err_retire    = 0;
    err_jump      = 0;
    err_load      = 0;
    err_misc      = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    @(negedge clk_i);
    check_reset_outputs();

    // Run the program until every instruction has retired
    while (accepted < NUM_INSTR || exp_waddr_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      drive_inputs();
      @(negedge clk_i);
      sample_outputs();
    end

    // Idle cycles to catch stray reports
    repeat (DRAIN_CYCLES) begin
      @(posedge clk_i);
      #1;
      drive_inputs();
      @(negedge clk_i);
      sample_outputs();
    end

    assert (exp_waddr_q.size() == 0 && exp_jump_q.size() == 0 &&
            exp_laddr_q.size() == 0) else begin
      err_misc++;
      $display("Expected retires, jumps or loads were never reported by the DUT");
    end

    print_counts();
    if (err_retire + err_jump + err_load + err_misc == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Cycle limit from the program length
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
             cycle_cnt, accepted, NUM_INSTR);
    print_counts();
    $display("Something failed");
    $finish;
  end

endmodule
